// File: hdl/rv_core_pkg.sv
/* Shared types, ALU operation and controller state encodings, and RV32I opcodes.
   Imported by every unit of the multicycle core. */
`default_nettype none

package rv_core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [31:0] pc_t;

    // pass-b carries the U-immediate straight through for lui
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_PASS_B
    } alu_op_t;

    typedef enum logic [2:0] {
        PAUSED,
        FETCH,
        DECODE,
        EXECUTE,
        MEM_WAIT,
        WRITEBACK
    } ctrl_state_t;

    // ------------------------------
    // major opcodes
    // ------------------------------
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

endpackage

`default_nettype wire

// File: hdl/rv_fetch.sv
/* Program counter and instruction register of the core.
   The PC is loaded on start, stepped by one word, and the IR takes the memory word. */
`timescale 1ns/1ps
`default_nettype none

module rv_fetch #(
    parameter int MEM_ADDR_BITS = 12
) (
    input  wire                      clk,
    input  wire                      rst_i,
    input  wire  rv_core_pkg::pc_t   start_addr_i,
    input  wire                      pc_load_i,
    input  wire                      pc_advance_i,
    input  wire                      ir_load_i,
    input  wire  rv_core_pkg::word_t mem_rdata_i,
    output rv_core_pkg::pc_t         pc_o,
    output rv_core_pkg::word_t       ir_o
);
    import rv_core_pkg::*;

    // pc kept as a word address, only as wide as the memory
    logic [MEM_ADDR_BITS-1:0] pc_word_q;
    word_t                    ir_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_word_q <= '0;
        end else if (pc_load_i) begin
            pc_word_q <= start_addr_i[MEM_ADDR_BITS+1:2];
        end else if (pc_advance_i) begin
            pc_word_q <= pc_word_q + MEM_ADDR_BITS'(1);
        end
    end

    // an all-zero word decodes as a no-op
    always_ff @(posedge clk) begin
        if (rst_i) begin
            ir_q <= '0;
        end else if (ir_load_i) begin
            ir_q <= mem_rdata_i;
        end
    end

    assign pc_o = {{(30 - MEM_ADDR_BITS){1'b0}}, pc_word_q, 2'b00};
    assign ir_o = ir_q;

endmodule

`default_nettype wire

// File: hdl/rv_decode.sv
/* Combinational instruction decoder for the supported RV32I subset.
   Gives register indices, the immediate, the ALU operation and class flags. */
`timescale 1ns/1ps
`default_nettype none

module rv_decode (
    input  wire  rv_core_pkg::word_t ir_i,
    output rv_core_pkg::reg_addr_t   rs1_o,
    output rv_core_pkg::reg_addr_t   rs2_o,
    output rv_core_pkg::reg_addr_t   rd_o,
    output rv_core_pkg::word_t       imm_o,
    output rv_core_pkg::alu_op_t     alu_op_o,
    output logic                     use_imm_o,
    output logic                     is_load_o,
    output logic                     is_store_o,
    output logic                     is_ebreak_o,
    output logic                     writes_rd_o
);
    import rv_core_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    word_t      imm_i_type;
    word_t      imm_s_type;
    word_t      imm_u_type;

    // funct3 mapping shared by register and immediate forms
    function automatic alu_op_t funct3_to_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign opcode = ir_i[6:0];
    assign funct3 = ir_i[14:12];

    assign rs1_o = ir_i[19:15];
    assign rs2_o = ir_i[24:20];
    assign rd_o  = ir_i[11:7];

    // ------------------------------
    // immediates
    // ------------------------------
    assign imm_i_type = {{20{ir_i[31]}}, ir_i[31:20]};
    assign imm_s_type = {{20{ir_i[31]}}, ir_i[31:25], ir_i[11:7]};
    assign imm_u_type = {ir_i[31:12], 12'h000};

    always_comb begin
        // unknown opcodes fall through as a no-op
        imm_o       = imm_i_type;
        alu_op_o    = ALU_ADD;
        use_imm_o   = 1'b0;
        is_load_o   = 1'b0;
        is_store_o  = 1'b0;
        is_ebreak_o = 1'b0;
        writes_rd_o = 1'b0;
        case (opcode)
            OPC_OP: begin
                alu_op_o    = funct3_to_op(funct3, ir_i[30]);
                writes_rd_o = 1'b1;
            end
            OPC_OP_IMM: begin
                // only srai uses bit 30, addi never subtracts
                alu_op_o    = funct3_to_op(funct3, (funct3 == 3'b101) && ir_i[30]);
                use_imm_o   = 1'b1;
                writes_rd_o = 1'b1;
            end
            OPC_LUI: begin
                imm_o       = imm_u_type;
                alu_op_o    = ALU_PASS_B;
                use_imm_o   = 1'b1;
                writes_rd_o = 1'b1;
            end
            OPC_LOAD: begin
                is_load_o   = 1'b1;
                writes_rd_o = 1'b1;
            end
            OPC_STORE: begin
                imm_o      = imm_s_type;
                is_store_o = 1'b1;
            end
            OPC_SYSTEM: begin
                // exact ebreak encoding, other system words are no-ops
                is_ebreak_o = (ir_i[31:7] == {12'h001, 13'h0000});
            end
            default: begin
                writes_rd_o = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/rv_reg_file.sv
/* 32-entry register file with x0 fixed at zero.
   While paused the debug port owns the write port and the second read port. */
`timescale 1ns/1ps
`default_nettype none

module rv_reg_file (
    input  wire                          clk,
    input  wire                          rst_i,
    input  wire                          paused_i,
    input  wire  rv_core_pkg::reg_addr_t rs1_addr_i,
    input  wire  rv_core_pkg::reg_addr_t rs2_addr_i,
    output rv_core_pkg::word_t           rs1_data_o,
    output rv_core_pkg::word_t           rs2_data_o,
    input  wire  rv_core_pkg::reg_addr_t rd_addr_i,
    input  wire                          rd_we_i,
    input  wire  rv_core_pkg::word_t     rd_data_i,
    input  wire  rv_core_pkg::reg_addr_t dbg_reg_addr_i,
    input  wire                          dbg_reg_we_i,
    input  wire  rv_core_pkg::word_t     dbg_reg_wdata_i,
    output rv_core_pkg::word_t           dbg_reg_rdata_o
);
    import rv_core_pkg::*;

    word_t     regs [1:31];
    reg_addr_t port_b_addr;
    reg_addr_t wr_addr;
    word_t     wr_data;
    logic      wr_en;

    // port sharing between core and debugger
    assign port_b_addr = paused_i ? dbg_reg_addr_i  : rs2_addr_i;
    assign wr_addr     = paused_i ? dbg_reg_addr_i  : rd_addr_i;
    assign wr_data     = paused_i ? dbg_reg_wdata_i : rd_data_i;
    assign wr_en       = paused_i ? dbg_reg_we_i    : rd_we_i;

    assign rs1_data_o = (rs1_addr_i == '0)  ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (port_b_addr == '0) ? '0 : regs[port_b_addr];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // debug read lands one cycle after the address
    always_ff @(posedge clk) begin
        dbg_reg_rdata_o <= rs2_data_o;
    end

endmodule

`default_nettype wire

// File: hdl/rv_alu.sv
/* Integer ALU for the RV32I register and immediate operations.
   Purely combinational, shift amounts come from the low five bits of b. */
`timescale 1ns/1ps
`default_nettype none

module rv_alu (
    input  wire  rv_core_pkg::alu_op_t op_i,
    input  wire  rv_core_pkg::word_t   a_i,
    input  wire  rv_core_pkg::word_t   b_i,
    output rv_core_pkg::word_t         result_o
);
    import rv_core_pkg::*;

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b_i[4:0];
    assign lt_signed   = $signed(a_i) < $signed(b_i);
    assign lt_unsigned = a_i < b_i;

    always_comb begin
        case (op_i)
            ALU_ADD:    result_o = a_i + b_i;
            ALU_SUB:    result_o = a_i - b_i;
            ALU_AND:    result_o = a_i & b_i;
            ALU_OR:     result_o = a_i | b_i;
            ALU_XOR:    result_o = a_i ^ b_i;
            // compares give 0 or 1
            ALU_SLT:    result_o = {31'b0, lt_signed};
            ALU_SLTU:   result_o = {31'b0, lt_unsigned};
            ALU_SLL:    result_o = a_i << shamt;
            ALU_SRL:    result_o = a_i >> shamt;
            ALU_SRA:    result_o = word_t'($signed(a_i) >>> shamt);
            ALU_PASS_B: result_o = b_i;
            default:    result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/rv_data_access.sv
/* Drives the single external memory port for both fetch and load/store.
   Also holds the load word and picks the value written back to rd. */
`timescale 1ns/1ps
`default_nettype none

module rv_data_access #(
    parameter int MEM_ADDR_BITS = 12
) (
    input  wire                           clk,
    input  wire                           rst_i,
    input  wire  rv_core_pkg::ctrl_state_t state_i,
    input  wire  rv_core_pkg::pc_t        pc_i,
    input  wire  rv_core_pkg::word_t      rs1_data_i,
    input  wire  rv_core_pkg::word_t      rs2_data_i,
    input  wire  rv_core_pkg::word_t      imm_i,
    input  wire                           is_load_i,
    input  wire                           is_store_i,
    input  wire  rv_core_pkg::word_t      alu_result_i,
    input  wire  rv_core_pkg::word_t      mem_rdata_i,
    output logic [MEM_ADDR_BITS-1:0]      mem_addr_o,
    output logic                          mem_we_o,
    output rv_core_pkg::word_t            mem_wdata_o,
    output rv_core_pkg::word_t            rd_data_o
);
    import rv_core_pkg::*;

    word_t eff_addr;
    logic  data_phase;
    word_t load_q;

    // byte offset bits are dropped, all accesses are whole words
    assign eff_addr   = rs1_data_i + imm_i;
    assign data_phase = (state_i == EXECUTE) && (is_load_i || is_store_i);

    assign mem_addr_o  = data_phase ? eff_addr[MEM_ADDR_BITS+1:2] : pc_i[MEM_ADDR_BITS+1:2];
    assign mem_we_o    = (state_i == EXECUTE) && is_store_i;
    assign mem_wdata_o = rs2_data_i;

    // read data for the EXECUTE address shows up in MEM_WAIT
    always_ff @(posedge clk) begin
        if (rst_i) begin
            load_q <= '0;
        end else if (state_i == MEM_WAIT) begin
            load_q <= mem_rdata_i;
        end
    end

    assign rd_data_o = is_load_i ? load_q : alu_result_i;

endmodule

`default_nettype wire

// File: hdl/rv_controller.sv
/* Multicycle control FSM, one pass per instruction.
   Starts from PAUSED on a start pulse and returns there on ebreak. */
`timescale 1ns/1ps
`default_nettype none

module rv_controller (
    input  wire                    clk,
    input  wire                    rst_i,
    input  wire                    start_i,
    input  wire                    is_load_i,
    input  wire                    is_store_i,
    input  wire                    is_ebreak_i,
    input  wire                    writes_rd_i,
    output rv_core_pkg::ctrl_state_t state_o,
    output logic                   pc_load_o,
    output logic                   pc_advance_o,
    output logic                   ir_load_o,
    output logic                   rd_we_o,
    output logic                   processor_paused_o
);
    import rv_core_pkg::*;

    ctrl_state_t state_q;
    ctrl_state_t state_d;

    // ------------------------------
    // next state
    // ------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            PAUSED: begin
                // start while running never reaches here
                if (start_i) begin
                    state_d = FETCH;
                end
            end
            FETCH:     state_d = DECODE;
            DECODE:    state_d = EXECUTE;
            EXECUTE: begin
                if (is_load_i || is_store_i) begin
                    state_d = MEM_WAIT;
                end else begin
                    state_d = WRITEBACK;
                end
            end
            MEM_WAIT:  state_d = WRITEBACK;
            WRITEBACK: begin
                if (is_ebreak_i) begin
                    state_d = PAUSED;
                end else begin
                    state_d = FETCH;
                end
            end
            default:   state_d = PAUSED;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= PAUSED;
        end else begin
            state_q <= state_d;
        end
    end

    // ------------------------------
    // strobes
    // ------------------------------
    assign pc_load_o    = (state_q == PAUSED) && start_i;
    // ebreak keeps its own address in the pc
    assign pc_advance_o = (state_q == WRITEBACK) && !is_ebreak_i;
    // memory word for the fetch address is valid in DECODE
    assign ir_load_o    = (state_q == DECODE);
    assign rd_we_o      = (state_q == WRITEBACK) && writes_rd_i;

    assign processor_paused_o = (state_q == PAUSED);
    assign state_o            = state_q;

endmodule

`default_nettype wire

// File: hdl/rv_core_top.sv
/* Top level of the multicycle RV32I core.
   Connects the units to one word memory and the paused-time register debug port. */
`timescale 1ns/1ps
`default_nettype none

module rv_core_top #(
    parameter int MEM_ADDR_BITS = 12
) (
    input  wire                          clk,
    input  wire                          rst_i,
    input  wire                          start_i,
    input  wire  rv_core_pkg::pc_t       start_addr_i,
    output logic [MEM_ADDR_BITS-1:0]     mem_addr_o,
    output logic                         mem_we_o,
    output rv_core_pkg::word_t           mem_wdata_o,
    input  wire  rv_core_pkg::word_t     mem_rdata_i,
    input  wire  rv_core_pkg::reg_addr_t dbg_reg_addr_i,
    input  wire                          dbg_reg_we_i,
    input  wire  rv_core_pkg::word_t     dbg_reg_wdata_i,
    output rv_core_pkg::word_t           dbg_reg_rdata_o,
    output rv_core_pkg::pc_t             peek_pc_o,
    output logic                         processor_paused_o
);
    import rv_core_pkg::*;

    ctrl_state_t state;
    logic        pc_load;
    logic        pc_advance;
    logic        ir_load;
    logic        rd_we;
    word_t       ir;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    reg_addr_t   rd;
    word_t       imm;
    alu_op_t     alu_op;
    logic        use_imm;
    logic        is_load;
    logic        is_store;
    logic        is_ebreak;
    logic        writes_rd;
    word_t       rs1_data;
    word_t       rs2_data;
    word_t       alu_b;
    word_t       alu_result;
    word_t       rd_data;

    // second ALU operand
    assign alu_b = use_imm ? imm : rs2_data;

    rv_controller u_controller (
        .clk                (clk),
        .rst_i              (rst_i),
        .start_i            (start_i),
        .is_load_i          (is_load),
        .is_store_i         (is_store),
        .is_ebreak_i        (is_ebreak),
        .writes_rd_i        (writes_rd),
        .state_o            (state),
        .pc_load_o          (pc_load),
        .pc_advance_o       (pc_advance),
        .ir_load_o          (ir_load),
        .rd_we_o            (rd_we),
        .processor_paused_o (processor_paused_o)
    );

    rv_fetch #(
        .MEM_ADDR_BITS (MEM_ADDR_BITS)
    ) u_fetch (
        .clk          (clk),
        .rst_i        (rst_i),
        .start_addr_i (start_addr_i),
        .pc_load_i    (pc_load),
        .pc_advance_i (pc_advance),
        .ir_load_i    (ir_load),
        .mem_rdata_i  (mem_rdata_i),
        .pc_o         (peek_pc_o),
        .ir_o         (ir)
    );

    rv_decode u_decode (
        .ir_i        (ir),
        .rs1_o       (rs1),
        .rs2_o       (rs2),
        .rd_o        (rd),
        .imm_o       (imm),
        .alu_op_o    (alu_op),
        .use_imm_o   (use_imm),
        .is_load_o   (is_load),
        .is_store_o  (is_store),
        .is_ebreak_o (is_ebreak),
        .writes_rd_o (writes_rd)
    );

    rv_reg_file u_reg_file (
        .clk             (clk),
        .rst_i           (rst_i),
        .paused_i        (processor_paused_o),
        .rs1_addr_i      (rs1),
        .rs2_addr_i      (rs2),
        .rs1_data_o      (rs1_data),
        .rs2_data_o      (rs2_data),
        .rd_addr_i       (rd),
        .rd_we_i         (rd_we),
        .rd_data_i       (rd_data),
        .dbg_reg_addr_i  (dbg_reg_addr_i),
        .dbg_reg_we_i    (dbg_reg_we_i),
        .dbg_reg_wdata_i (dbg_reg_wdata_i),
        .dbg_reg_rdata_o (dbg_reg_rdata_o)
    );

    rv_alu u_alu (
        .op_i     (alu_op),
        .a_i      (rs1_data),
        .b_i      (alu_b),
        .result_o (alu_result)
    );

    rv_data_access #(
        .MEM_ADDR_BITS (MEM_ADDR_BITS)
    ) u_data_access (
        .clk          (clk),
        .rst_i        (rst_i),
        .state_i      (state),
        .pc_i         (peek_pc_o),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .imm_i        (imm),
        .is_load_i    (is_load),
        .is_store_i   (is_store),
        .alu_result_i (alu_result),
        .mem_rdata_i  (mem_rdata_i),
        .mem_addr_o   (mem_addr_o),
        .mem_we_o     (mem_we_o),
        .mem_wdata_o  (mem_wdata_o),
        .rd_data_o    (rd_data)
    );

endmodule

`default_nettype wire

// File: dv/rv_ref_model.svh
/* Instruction-level model of the core with its own register and memory copy.
   Included inside the testbench module, which provides MEM_ADDR_BITS and MEM_WORDS. */
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

localparam word_t EBREAK_WORD = 32'h0010_0073;

word_t model_regs [32];
word_t model_mem  [MEM_WORDS];

// memory word index of a byte address, low two bits dropped
function automatic logic [MEM_ADDR_BITS-1:0] word_index(input word_t byte_addr);
    return byte_addr[MEM_ADDR_BITS+1:2];
endfunction

// funct3 meaning from the base ISA, alt picks sub and sra
function automatic word_t compute_alu(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
    logic [4:0] sh;
    sh = b[4:0];
    case (f3)
        3'b000:  return alt ? a - b : a + b;
        3'b001:  return a << sh;
        // signs differ, so the negative one is smaller
        3'b010:  return {31'b0, (a[31] != b[31]) ? a[31] : (a < b)};
        3'b011:  return {31'b0, a < b};
        3'b100:  return a ^ b;
        3'b101:  return alt ? ((a >> sh) | (~(32'hffff_ffff >> sh) & {32{a[31]}})) : (a >> sh);
        3'b110:  return a | b;
        default: return a & b;
    endcase
endfunction

function automatic void execute_instruction(input word_t ir);
    logic [6:0] opc;
    logic [2:0] f3;
    reg_addr_t  rd;
    word_t      a;
    word_t      b;
    word_t      imm_i;
    word_t      imm_s;
    word_t      res;
    logic       writes;
    opc    = ir[6:0];
    f3     = ir[14:12];
    rd     = ir[11:7];
    a      = model_regs[ir[19:15]];
    b      = model_regs[ir[24:20]];
    imm_i  = {{20{ir[31]}}, ir[31:20]};
    imm_s  = {{20{ir[31]}}, ir[31:25], ir[11:7]};
    res    = '0;
    writes = 1'b1;
    case (opc)
        OPC_OP:     res = compute_alu(f3, ir[30], a, b);
        OPC_OP_IMM: res = compute_alu(f3, ir[30] && (f3 == 3'b101), a, imm_i);
        OPC_LUI:    res = {ir[31:12], 12'h000};
        OPC_LOAD:   res = model_mem[word_index(a + imm_i)];
        OPC_STORE: begin
            model_mem[word_index(a + imm_s)] = b;
            writes = 1'b0;
        end
        // non-ebreak system words and unknown opcodes do nothing
        default:    writes = 1'b0;
    endcase
    if (writes && rd != 5'd0) begin
        model_regs[rd] = res;
    end
endfunction

// steps from start_pc until ebreak, gives back the ebreak address
function automatic pc_t run_until_ebreak(input pc_t start_pc, input int max_steps);
    pc_t   pc;
    word_t ir;
    int    s;
    pc = start_pc;
    for (s = 0; s < max_steps; s++) begin
        ir = model_mem[word_index(pc)];
        if (ir == EBREAK_WORD) begin
            return pc;
        end
        execute_instruction(ir);
        pc = pc + 32'd4;
    end
    return pc;
endfunction

`endif

// File: dv/tb_rv_core.sv
/* Self-checking testbench for the multicycle RV32I core.
   Runs random programs from a fixed seed and compares against the instruction model. */
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;
    import rv_core_pkg::*;

    localparam int  MEM_ADDR_BITS = 12;
    localparam int  MEM_WORDS     = 1 << MEM_ADDR_BITS;
    localparam int  DATA_WORD0    = 'h100;
    localparam int  DATA_WORDS    = 64;
    localparam int  RUNS          = 6;
    localparam int  MIX_ALU       = 0;
    localparam int  MIX_MEM       = 1;
    localparam int  MIX_JUNK      = 2;
    localparam pc_t PROG_A        = 32'h0000_1000;
    localparam pc_t PROG_B        = 32'h0000_2000;

    logic                     clk;
    logic                     rst_i;
    logic                     start_i;
    pc_t                      start_addr_i;
    logic [MEM_ADDR_BITS-1:0] mem_addr_o;
    logic                     mem_we_o;
    word_t                    mem_wdata_o;
    word_t                    mem_rdata_i = '0;
    reg_addr_t                dbg_reg_addr_i;
    logic                     dbg_reg_we_i;
    word_t                    dbg_reg_wdata_i;
    word_t                    dbg_reg_rdata_o;
    pc_t                      peek_pc_o;
    logic                     processor_paused_o;

    word_t                    mem [MEM_WORDS];
    logic                     load_we;
    logic [MEM_ADDR_BITS-1:0] load_addr;
    word_t                    load_data;
    int                       checks = 0;
    int                       errors = 0;
    logic                     timed_out = 1'b0;

    `include "rv_ref_model.svh"

    rv_core_top #(
        .MEM_ADDR_BITS (MEM_ADDR_BITS)
    ) dut0 (
        .clk                (clk),
        .rst_i              (rst_i),
        .start_i            (start_i),
        .start_addr_i       (start_addr_i),
        .mem_addr_o         (mem_addr_o),
        .mem_we_o           (mem_we_o),
        .mem_wdata_o        (mem_wdata_o),
        .mem_rdata_i        (mem_rdata_i),
        .dbg_reg_addr_i     (dbg_reg_addr_i),
        .dbg_reg_we_i       (dbg_reg_we_i),
        .dbg_reg_wdata_i    (dbg_reg_wdata_i),
        .dbg_reg_rdata_o    (dbg_reg_rdata_o),
        .peek_pc_o          (peek_pc_o),
        .processor_paused_o (processor_paused_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic word_t fill_word(input int unsigned a);
        return word_t'(a * 32'h9e37_79b9) ^ 32'h5a5a_0000;
    endfunction

    // ------------------------------
    // word memory, one-cycle read
    // ------------------------------
    always @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= fill_word(i);
            end
        end else if (load_we) begin
            mem[load_addr] <= load_data;
        end else if (mem_we_o) begin
            mem[mem_addr_o] <= mem_wdata_o;
        end
        mem_rdata_i <= mem[mem_addr_o];
    end

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_pc(input string name, input pc_t expected, input pc_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    // ------------------------------
    // random instruction words
    // ------------------------------
    function automatic word_t alu_instruction();
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        f3  = 3'($urandom);
        rd  = 5'($urandom);
        rs1 = 5'($urandom);
        rs2 = 5'($urandom);
        imm = 12'($urandom);
        case ($urandom_range(2))
            0: begin
                f7 = ((f3 == 3'b000 || f3 == 3'b101) && $urandom_range(1) == 1) ? 7'h20 : 7'h00;
                return {f7, rs2, rs1, f3, rd, OPC_OP};
            end
            1: begin
                // shift immediates keep only the shift amount and the sra bit
                if (f3 == 3'b001 || f3 == 3'b101) begin
                    imm[11:5] = (f3 == 3'b101 && $urandom_range(1) == 1) ? 7'h20 : 7'h00;
                end
                return {imm, rs1, f3, rd, OPC_OP_IMM};
            end
            default: return {20'($urandom), rd, OPC_LUI};
        endcase
    endfunction

    // x0 base, so the immediate alone lands in the data region
    function automatic word_t load_store_instruction();
        logic [11:0] offset;
        reg_addr_t   reg_sel;
        offset  = 12'(DATA_WORD0 * 4 + 4 * $urandom_range(DATA_WORDS - 1));
        reg_sel = 5'($urandom);
        if ($urandom_range(1) == 1) begin
            return {offset, 5'd0, 3'b010, reg_sel, OPC_LOAD};
        end
        return {offset[11:5], reg_sel, 5'd0, 3'b010, offset[4:0], OPC_STORE};
    endfunction

    function automatic word_t unsupported_word();
        logic [6:0] opc;
        do begin
            opc = 7'($urandom);
        end while (opc inside {OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_LOAD, OPC_STORE, OPC_SYSTEM});
        return {25'($urandom), opc};
    endfunction

    // ------------------------------
    // DUT access
    // ------------------------------
    task automatic write_reg(input reg_addr_t addr, input word_t data);
        @(posedge clk);
        dbg_reg_addr_i  <= addr;
        dbg_reg_wdata_i <= data;
        dbg_reg_we_i    <= 1'b1;
        @(posedge clk);
        dbg_reg_we_i    <= 1'b0;
        if (addr != 5'd0) begin
            model_regs[addr] = data;
        end
    endtask

    task automatic read_reg(input reg_addr_t addr, output word_t data);
        @(posedge clk);
        dbg_reg_addr_i <= addr;
        @(posedge clk);
        @(negedge clk);
        data = dbg_reg_rdata_o;
    endtask

    task automatic compare_registers(input string name);
        word_t v;
        int    r;
        for (r = 0; r < 32; r++) begin
            read_reg(reg_addr_t'(r), v);
            check_word($sformatf("%s x%0d", name, r), model_regs[r], v);
        end
    endtask

    task automatic load_program(input pc_t base, input int count, input int mix);
        word_t                    w;
        logic [MEM_ADDR_BITS-1:0] a;
        int                       i;
        a = base[MEM_ADDR_BITS+1:2];
        for (i = 0; i <= count; i++) begin
            if (i == count) begin
                w = EBREAK_WORD;
            end else if (mix == MIX_MEM && $urandom_range(2) != 0) begin
                w = load_store_instruction();
            end else if (mix == MIX_JUNK && $urandom_range(3) == 0) begin
                w = unsupported_word();
            end else begin
                w = alu_instruction();
            end
            @(posedge clk);
            load_we   <= 1'b1;
            load_addr <= a;
            load_data <= w;
            model_mem[a] = w;
            a = a + 1'b1;
        end
        @(posedge clk);
        load_we <= 1'b0;
    endtask

    task automatic start_core(input pc_t addr);
        @(posedge clk);
        start_addr_i <= addr;
        start_i      <= 1'b1;
        @(posedge clk);
        start_i      <= 1'b0;
        @(negedge clk);
        check_flag("start leaves pause", 1'b0, processor_paused_o);
    endtask

    task automatic wait_for_pause(input string name, input int max_cycles);
        int n;
        n = 0;
        while (processor_paused_o !== 1'b1 && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        if (processor_paused_o !== 1'b1) begin
            errors++;
            timed_out = 1'b1;
            $display("%s: core did not pause within %0d cycles", name, max_cycles);
        end
    endtask

    task automatic run_program(input string name, input pc_t base, input int count,
                               input int mix);
        pc_t expected_pc;
        int  r;
        int  k;
        for (r = 1; r < 32; r++) begin
            write_reg(reg_addr_t'(r), $urandom);
        end
        load_program(base, count, mix);
        expected_pc = run_until_ebreak(base, count + 1);
        start_core(base);
        wait_for_pause(name, 8 * count + 40);
        if (!timed_out) begin
            check_pc({name, " ebreak pc"}, expected_pc, peek_pc_o);
            check_flag({name, " mem_we idle"}, 1'b0, mem_we_o);
            compare_registers(name);
            for (k = 0; k < DATA_WORDS; k++) begin
                check_word($sformatf("%s mem[%0h]", name, DATA_WORD0 + k),
                           model_mem[DATA_WORD0 + k], mem[DATA_WORD0 + k]);
            end
        end
    endtask

    initial begin
        reg_addr_t r;
        word_t     v;
        int        i;
        int        run;
        pc_t       base;
        void'($urandom(32'h5e1e));
        rst_i           <= 1'b1;
        start_i         <= 1'b0;
        start_addr_i    <= '0;
        dbg_reg_addr_i  <= '0;
        dbg_reg_we_i    <= 1'b0;
        dbg_reg_wdata_i <= '0;
        load_we         <= 1'b0;
        load_addr       <= '0;
        load_data       <= '0;
        for (i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        for (i = 0; i < MEM_WORDS; i++) begin
            model_mem[i] = fill_word(i);
        end
        repeat (16) @(posedge clk);
        rst_i <= 1'b0;
        @(negedge clk);

        check_flag("reset paused", 1'b1, processor_paused_o);
        check_flag("reset mem_we", 1'b0, mem_we_o);
        compare_registers("reset");

        // debug port round trips, x0 stays zero
        for (i = 0; i < 40; i++) begin
            r = reg_addr_t'($urandom_range(31));
            write_reg(r, $urandom);
            read_reg(r, v);
            check_word($sformatf("debug x%0d", r), model_regs[r], v);
        end
        write_reg(5'd0, 32'hdead_beef);
        read_reg(5'd0, v);
        check_word("debug x0", 32'h0, v);

        // runs alternate between two start addresses
        for (run = 0; run < RUNS && !timed_out; run++) begin
            base = run[0] ? PROG_B : PROG_A;
            run_program($sformatf("alu run %0d", run), base, 16 + $urandom_range(16), MIX_ALU);
        end
        for (run = 0; run < RUNS && !timed_out; run++) begin
            base = run[0] ? PROG_B : PROG_A;
            run_program($sformatf("mem run %0d", run), base, 16 + $urandom_range(16), MIX_MEM);
        end
        for (run = 0; run < RUNS && !timed_out; run++) begin
            base = run[0] ? PROG_B : PROG_A;
            run_program($sformatf("junk run %0d", run), base, 16 + $urandom_range(16),
                        MIX_JUNK);
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+dv
hdl/rv_core_pkg.sv
hdl/rv_fetch.sv
hdl/rv_decode.sv
hdl/rv_reg_file.sv
hdl/rv_alu.sv
hdl/rv_data_access.sv
hdl/rv_controller.sv
hdl/rv_core_top.sv
dv/tb_rv_core.sv

// File: Makefile
# Verilator flow for the rv core testbench

TOP := tb_rv_core

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f tb.f --top-module rv_core_top

# the run passes only if the log holds the pass line
sim:
	verilator --binary --timing -f tb.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Test OK$$" sim.log

clean:
	rm -rf obj_dir sim.log
